//--- Makefile
# Verilator build and run for the ship duel pixel path

TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = ship_display_tb
FLIST = ship_display.f

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# The bitmap file is read relative to the project root
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/color_mapper.sv
// Picks each pixel's colour by layer priority and registers RGB with sync
// Output lags the scan counters by one clock
`default_nettype none
`timescale 1ns/1ps

module color_mapper (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [vga_pkg::coord_w-1:0]    draw_x,
    input  logic [vga_pkg::coord_w-1:0]    draw_y,
    input  logic                          blank,
    input  logic                          hsync,
    input  logic                          vsync,
    input  logic                          is_ship1,
    input  logic [palette_pkg::code_w-1:0] ship1_code,
    input  logic                          is_ship2,
    input  logic [palette_pkg::code_w-1:0] ship2_code,
    input  logic                          is_torp1,
    input  logic                          is_torp2,
    output logic [7:0]                    vga_r,
    output logic [7:0]                    vga_g,
    output logic [7:0]                    vga_b,
    output logic                          vga_hs,
    output logic                          vga_vs
);

    logic [vga_pkg::coord_w-vga_pkg::tile_shift:0] tile_sum;
    logic [1:0]                                   bg_idx;

    logic [palette_pkg::color_w-1:0] bg_color;
    logic [palette_pkg::color_w-1:0] ship1_color;
    logic [palette_pkg::color_w-1:0] ship2_color;
    logic [palette_pkg::color_w-1:0] color;

    // --------------------
    // Tile column plus tile row, mod 3, gives the diagonal stripes
    assign tile_sum = {1'b0, draw_x[vga_pkg::coord_w-1:vga_pkg::tile_shift]} +
                      {1'b0, draw_y[vga_pkg::coord_w-1:vga_pkg::tile_shift]};
    assign bg_idx   = 2'(tile_sum % 3);

    // Palette lookups
    assign bg_color    = palette_pkg::background_palette[bg_idx];
    assign ship1_color = palette_pkg::ship_palette[ship1_code];
    assign ship2_color = palette_pkg::ship_palette[ship2_code];

    // --------------------
    // Ship 1 over ship 2 over torpedoes over background
    always_comb
    begin
        if (is_ship1)
            // Key green lets the background through
            color = (ship1_color == palette_pkg::key_color) ? bg_color : ship1_color;
        else if (is_ship2)
            color = (ship2_color == palette_pkg::key_color) ? bg_color : ship2_color;
        else if (is_torp1 || is_torp2)
            color = palette_pkg::torp_color;
        else
            color = bg_color;

        // Dark outside the visible area
        if (blank)
            color = '0;
    end

    // --------------------
    // Colour and sync leave together so they stay aligned
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
        end
        else
        begin
            vga_r  <= color[23:16];
            vga_g  <= color[15:8];
            vga_b  <= color[7:0];
            vga_hs <= hsync;
            vga_vs <= vsync;
        end
    end

    // Blanked position is black one clock later
    a_blank_black: assert property (
        @(posedge clk) disable iff (!rst_n)
        blank |=> (vga_r == 8'd0) && (vga_g == 8'd0) && (vga_b == 8'd0)
    );

endmodule

`default_nettype wire

//--- rtl/palette_pkg.sv
// Colour codes and palettes for ships, torpedoes and the tiled background
// Referenced by scope from the sprite and colour mapper blocks
`default_nettype none

package palette_pkg;

    // Width of a sprite palette code
    localparam int code_w  = 4;
    // Width of one RGB colour, 8 bits per channel
    localparam int color_w = 24;

    // --------------------
    // Ship palette, indexed by bitmap cell code
    // Code 5 is the transparent green
    localparam logic [color_w-1:0] ship_palette [16] = '{
        24'hFFF3DC,
        24'hCCC1D3,
        24'hAE3F4C,
        24'h9D834D,
        24'h020101,
        24'h00FF00,
        24'hF0CCAF,
        24'hFFFBEB,
        24'h766C96,
        24'hE3998A,
        24'h59667F,
        24'h535C74,
        24'hAB9B9E,
        24'hDFE5EB,
        24'h000000,
        24'hFFFFFF
    };

    // Three blues for the tile pattern
    localparam logic [color_w-1:0] background_palette [3] = '{
        24'h3FB9E9,
        24'h0AA5E8,
        24'h04A3E8
    };

    // --------------------
    // Sprite pixels of this colour let the background through
    localparam logic [color_w-1:0] key_color  = 24'h00FF00;
    // Off-white shared by both players' shots
    localparam logic [color_w-1:0] torp_color = 24'hFFFBEB;

endpackage

`default_nettype wire

//--- rtl/ship_display.sv
// Top of the duel pixel path: scan timing, two ships, two torpedo banks
// Ship positions and fire strobes come from outside; VGA pins lag the scan by a clock
`default_nettype none
`timescale 1ns/1ps

module ship_display (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [vga_pkg::coord_w-1:0] ship1_x,
    input  logic [vga_pkg::coord_w-1:0] ship1_y,
    input  logic [vga_pkg::coord_w-1:0] ship2_x,
    input  logic [vga_pkg::coord_w-1:0] ship2_y,
    input  logic                       fire1,
    input  logic                       fire2,
    output logic [7:0]                 vga_r,
    output logic [7:0]                 vga_g,
    output logic [7:0]                 vga_b,
    output logic                       vga_hs,
    output logic                       vga_vs
);

    // --------------------
    // Scan position and sync
    logic [vga_pkg::coord_w-1:0] draw_x;
    logic [vga_pkg::coord_w-1:0] draw_y;
    logic                        hsync;
    logic                        vsync;
    logic                        blank;
    logic                        frame_start;

    // Layer flags and codes
    logic                           is_ship1;
    logic                           is_ship2;
    logic [palette_pkg::code_w-1:0] ship1_code;
    logic [palette_pkg::code_w-1:0] ship2_code;
    logic                           is_torp1;
    logic                           is_torp2;

    vga_timing i_vga_timing (
        .clk         (clk),
        .rst_n       (rst_n),
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .hsync       (hsync),
        .vsync       (vsync),
        .blank       (blank),
        .frame_start (frame_start)
    );

    // --------------------
    // Player 1 on the left, firing right
    ship_sprite i_ship_sprite1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .ship_x    (ship1_x),
        .ship_y    (ship1_y),
        .is_ship   (is_ship1),
        .ship_code (ship1_code)
    );

    torpedo_bank #(.dir_left(1'b0)) i_torpedo_bank1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fire        (fire1),
        .ship_x      (ship1_x),
        .ship_y      (ship1_y),
        .frame_start (frame_start),
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .is_torp     (is_torp1)
    );

    // Player 2, firing left
    ship_sprite i_ship_sprite2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .ship_x    (ship2_x),
        .ship_y    (ship2_y),
        .is_ship   (is_ship2),
        .ship_code (ship2_code)
    );

    torpedo_bank #(.dir_left(1'b1)) i_torpedo_bank2 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fire        (fire2),
        .ship_x      (ship2_x),
        .ship_y      (ship2_y),
        .frame_start (frame_start),
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .is_torp     (is_torp2)
    );

    // --------------------
    // Final colour and registered pins
    color_mapper i_color_mapper (
        .clk        (clk),
        .rst_n      (rst_n),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .blank      (blank),
        .hsync      (hsync),
        .vsync      (vsync),
        .is_ship1   (is_ship1),
        .ship1_code (ship1_code),
        .is_ship2   (is_ship2),
        .ship2_code (ship2_code),
        .is_torp1   (is_torp1),
        .is_torp2   (is_torp2),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .vga_hs     (vga_hs),
        .vga_vs     (vga_vs)
    );

endmodule

`default_nettype wire

//--- rtl/ship_sprite.sv
// Ship hit test and bitmap lookup for one player
// Ship is the 8x8 ROM drawn at double size from its top-left corner
`default_nettype none
`timescale 1ns/1ps

module ship_sprite (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [vga_pkg::coord_w-1:0]    draw_x,
    input  logic [vga_pkg::coord_w-1:0]    draw_y,
    input  logic [vga_pkg::coord_w-1:0]    ship_x,
    input  logic [vga_pkg::coord_w-1:0]    ship_y,
    output logic                          is_ship,
    output logic [palette_pkg::code_w-1:0] ship_code
);

    // One word per bitmap row, column 0 in the top nibble
    logic [vga_pkg::sprite_cells*palette_pkg::code_w-1:0] rom [vga_pkg::sprite_cells];
    logic [vga_pkg::sprite_cells*palette_pkg::code_w-1:0] row_word;

    logic [vga_pkg::coord_w-1:0] dx;
    logic [vga_pkg::coord_w-1:0] dy;
    logic [vga_pkg::cell_w-1:0]  cell_col;
    logic [vga_pkg::cell_w-1:0]  cell_row;

    initial
    begin
        $readmemh("ship_sprite.mem", rom);
    end

    // --------------------
    // Offset inside the ship box
    assign dx = draw_x - ship_x;
    assign dy = draw_y - ship_y;

    // Box test, 16 pixels right of and below the corner
    assign is_ship = (draw_x >= ship_x) && (draw_x < ship_x + vga_pkg::sprite_size) &&
                     (draw_y >= ship_y) && (draw_y < ship_y + vga_pkg::sprite_size);

    // Halve to undo the double-size drawing
    assign cell_col = vga_pkg::cell_w'(dx / vga_pkg::sprite_scale);
    assign cell_row = vga_pkg::cell_w'(dy / vga_pkg::sprite_scale);

    // Cell code out of the row word
    assign row_word  = rom[cell_row];
    assign ship_code = row_word[(vga_pkg::sprite_cells - 1 - cell_col) * palette_pkg::code_w
                                +: palette_pkg::code_w];

    // Bitmap file must cover every cell the ship can show
    a_code_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_ship |-> !$isunknown(ship_code)
    );

endmodule

`default_nettype wire

//--- rtl/torpedo_bank.sv
// Four torpedo slots for one player, launched by fire and moved each frame
// dir_left set sends shots toward column 0
`default_nettype none
`timescale 1ns/1ps

module torpedo_bank #(
    parameter bit dir_left = 1'b0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fire,
    input  logic [vga_pkg::coord_w-1:0] ship_x,
    input  logic [vga_pkg::coord_w-1:0] ship_y,
    input  logic                       frame_start,
    input  logic [vga_pkg::coord_w-1:0] draw_x,
    input  logic [vga_pkg::coord_w-1:0] draw_y,
    output logic                       is_torp
);

    logic [vga_pkg::torp_slots-1:0] active;
    logic [vga_pkg::coord_w-1:0]    tx [vga_pkg::torp_slots];
    logic [vga_pkg::coord_w-1:0]    ty [vga_pkg::torp_slots];

    logic                        launch;
    logic [vga_pkg::slot_w-1:0]  free_idx;
    logic [vga_pkg::coord_w-1:0] launch_x;
    logic [vga_pkg::coord_w-1:0] launch_y;

    logic [vga_pkg::coord_w-1:0]    moved_x [vga_pkg::torp_slots];
    logic [vga_pkg::torp_slots-1:0] leaving;
    logic [vga_pkg::torp_slots-1:0] hit;

    // --------------------
    // Lowest free slot takes the shot, fire dropped when all busy
    always_comb
    begin
        launch   = 1'b0;
        free_idx = '0;
        for (int i = vga_pkg::torp_slots - 1; i >= 0; i--)
        begin
            if (!active[i])
            begin
                launch   = fire;
                free_idx = vga_pkg::slot_w'(i);
            end
        end
    end

    // Just past the ship nose, at mid height
    assign launch_x = dir_left ? ship_x - vga_pkg::coord_w'(vga_pkg::torp_len)
                               : ship_x + vga_pkg::coord_w'(vga_pkg::sprite_size);
    assign launch_y = ship_y + vga_pkg::coord_w'(vga_pkg::sprite_size / 2 - 1);

    // Per-frame step, and whether it leaves the visible columns
    always_comb
    begin
        for (int i = 0; i < vga_pkg::torp_slots; i++)
        begin
            if (dir_left)
            begin
                moved_x[i] = tx[i] - vga_pkg::coord_w'(vga_pkg::torp_step);
                leaving[i] = tx[i] < vga_pkg::torp_step;
            end
            else
            begin
                moved_x[i] = tx[i] + vga_pkg::coord_w'(vga_pkg::torp_step);
                leaving[i] = tx[i] + vga_pkg::torp_step >= vga_pkg::h_visible;
            end
        end
    end

    // --------------------
    // Slot flags; a freshly launched slot skips this frame's move
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            active <= '0;
        else
        begin
            for (int i = 0; i < vga_pkg::torp_slots; i++)
            begin
                if (launch && (free_idx == vga_pkg::slot_w'(i)))
                    active[i] <= 1'b1;
                else if (frame_start && active[i] && leaving[i])
                    active[i] <= 1'b0;
            end
        end
    end

    // Positions
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < vga_pkg::torp_slots; i++)
        begin
            if (launch && (free_idx == vga_pkg::slot_w'(i)))
            begin
                tx[i] <= launch_x;
                ty[i] <= launch_y;
            end
            else if (frame_start && active[i])
                tx[i] <= moved_x[i];
        end
    end

    // --------------------
    // Pixel inside any live 4x2 box
    always_comb
    begin
        for (int i = 0; i < vga_pkg::torp_slots; i++)
            hit[i] = active[i] &&
                     (draw_x >= tx[i]) && (draw_x < tx[i] + vga_pkg::torp_len) &&
                     (draw_y >= ty[i]) && (draw_y < ty[i] + vga_pkg::torp_height);
    end

    assign is_torp = |hit;

    // Live shots stay on screen; retirement must beat the edge
    for (genvar g = 0; g < vga_pkg::torp_slots; g++)
    begin : g_slot_check
        a_on_screen: assert property (
            @(posedge clk) disable iff (!rst_n)
            active[g] |-> (tx[g] < vga_pkg::h_visible)
        );
    end

endmodule

`default_nettype wire

//--- rtl/vga_pkg.sv
// Screen timing and object geometry for the 640x480 ship duel display
// Referenced by scope from the timing, sprite, torpedo and mapper blocks
`default_nettype none

package vga_pkg;

    // Pixel coordinate width, enough for the 800-pixel line
    localparam int coord_w = 10;

    // --------------------
    // Horizontal timing, in pixels
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;

    // Vertical timing, in lines
    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;

    // --------------------
    // Ship bitmap, 8x8 cells drawn at double size
    localparam int sprite_scale = 2;
    localparam int sprite_cells = 8;
    localparam int sprite_size  = sprite_cells * sprite_scale;
    localparam int cell_w       = $clog2(sprite_cells);

    // Torpedo slots and box
    localparam int torp_slots  = 4;
    localparam int slot_w      = $clog2(torp_slots);
    localparam int torp_len    = 4;
    localparam int torp_height = 2;
    localparam int torp_step   = 8;

    // Background tiles are 32 pixels square
    localparam int tile_shift = 5;

endpackage

`default_nettype wire

//--- rtl/vga_timing.sv
// Scan generator for 640x480 VGA with registered pixel and line counters
// Sync and blank follow the counters in the same cycle
`default_nettype none
`timescale 1ns/1ps

module vga_timing (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [vga_pkg::coord_w-1:0] draw_x,
    output logic [vga_pkg::coord_w-1:0] draw_y,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       blank,
    output logic                       frame_start
);

    logic [vga_pkg::coord_w-1:0] next_x;
    logic [vga_pkg::coord_w-1:0] next_y;

    // --------------------
    // Next scan position
    always_comb
    begin
        next_x = draw_x + 1'b1;
        next_y = draw_y;
        // End of line wraps to column 0
        if (draw_x == vga_pkg::coord_w'(vga_pkg::h_total - 1))
        begin
            next_x = '0;
            // Last line wraps to the top
            if (draw_y == vga_pkg::coord_w'(vga_pkg::v_total - 1))
                next_y = '0;
            else
                next_y = draw_y + 1'b1;
        end
    end

    // Counters, plus strobe raised while the scan sits on (0,0)
    // Not raised on the first frame after reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            draw_x      <= '0;
            draw_y      <= '0;
            frame_start <= 1'b0;
        end
        else
        begin
            draw_x      <= next_x;
            draw_y      <= next_y;
            frame_start <= (next_x == '0) && (next_y == '0);
        end
    end

    // --------------------
    // Active-low sync pulses after the front porch
    assign hsync = !((draw_x >= vga_pkg::h_visible + vga_pkg::h_front) &&
                     (draw_x <  vga_pkg::h_visible + vga_pkg::h_front + vga_pkg::h_sync));
    assign vsync = !((draw_y >= vga_pkg::v_visible + vga_pkg::v_front) &&
                     (draw_y <  vga_pkg::v_visible + vga_pkg::v_front + vga_pkg::v_sync));

    // Outside the visible area
    assign blank = (draw_x >= vga_pkg::h_visible) || (draw_y >= vga_pkg::v_visible);

    // Counters never run past the frame
    a_counter_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (draw_x < vga_pkg::h_total) && (draw_y < vga_pkg::v_total)
    );

endmodule

`default_nettype wire

//--- ship_display.f
rtl/vga_pkg.sv
rtl/palette_pkg.sv
rtl/vga_timing.sv
rtl/ship_sprite.sv
rtl/torpedo_bank.sv
rtl/color_mapper.sv
rtl/ship_display.sv
verification/ship_display_tb.sv

//--- ship_sprite.mem
// Ship bitmap, one row per line, top row first
// Eight 4-bit palette codes per row, leftmost column in the top nibble
5EE55555
E87EE555
E8777EE5
E87C6629
E87C662A
E8777EE5
E87EE555
5EE55555

//--- verification/ship_display_tb.sv
// Testbench for the ship duel display over three frames from reset
// Compares every VGA output against a scan, sprite and torpedo model
`default_nettype none
`timescale 1ns/1ps

module ship_display_tb;

    // --------------------
    // Run length and limits
    localparam int frame_cycles   = vga_pkg::h_total * vga_pkg::v_total;
    localparam int run_frames     = 3;
    localparam int timeout_cycles = run_frames * frame_cycles + 240_000;

    // Launch offsets from the ship corner
    localparam int launch_ahead = 16;
    localparam int launch_back  = 4;
    localparam int launch_drop  = 7;
    localparam int tile_px      = 32;

    // Random ship area leaves room for an overlap offset of up to 7
    localparam int col_min = 40;
    localparam int col_max = 572;
    localparam int row_min = 40;
    localparam int row_max = 440;

    // Corners whose shots reach a screen edge within two frame starts
    localparam int edge_x_right = 612;
    localparam int edge_x_left  = 12;

    localparam logic [15:0] lfsr_taps = 16'hB400;

    logic clk = 1'b0;
    logic rst_n;
    logic [vga_pkg::coord_w-1:0] ship1_x;
    logic [vga_pkg::coord_w-1:0] ship1_y;
    logic [vga_pkg::coord_w-1:0] ship2_x;
    logic [vga_pkg::coord_w-1:0] ship2_y;
    logic fire1;
    logic fire2;
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic vga_hs;
    logic vga_vs;

    // Model state tracking the DUT counters and torpedo slots
    int scan_x = 0;
    int scan_y = 0;
    int frame_count = 0;
    int overlap_pixels = 0;
    int shot_pixels = 0;
    int cycle_count = 0;
    bit m_active [2][vga_pkg::torp_slots];
    int m_tx     [2][vga_pkg::torp_slots];
    int m_ty     [2][vga_pkg::torp_slots];
    logic [31:0] bitmap [vga_pkg::sprite_cells];
    logic [15:0] lfsr_state = 16'd7;

    // Expected outputs start at the reset state
    logic [23:0] exp_rgb = 24'h0;
    logic exp_hs = 1'b1;
    logic exp_vs = 1'b1;

    always #10 clk = ~clk;

    ship_display i_ship_display (
        .clk     (clk),
        .rst_n   (rst_n),
        .ship1_x (ship1_x),
        .ship1_y (ship1_y),
        .ship2_x (ship2_x),
        .ship2_y (ship2_y),
        .fire1   (fire1),
        .fire2   (fire2),
        .vga_r   (vga_r),
        .vga_g   (vga_g),
        .vga_b   (vga_b),
        .vga_hs  (vga_hs),
        .vga_vs  (vga_vs)
    );

    // --------------------
    // Random source
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ lfsr_taps;
        return state >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // --------------------
    // Pixel model
    function automatic bit on_ship(input int x, input int y, input int sx, input int sy);
        return (x >= sx) && (x < sx + 16) && (y >= sy) && (y < sy + 16);
    endfunction

    // Cell code at double size with column 0 in the top nibble
    function automatic logic [3:0] cell_code(input int x, input int y, input int sx,
                                             input int sy);
        int col;
        int row;
        col = (x - sx) / 2;
        row = (y - sy) / 2;
        return 4'(bitmap[row] >> ((7 - col) * 4));
    endfunction

    function automatic logic [23:0] ship_or_background(input logic [3:0] code,
                                                       input logic [23:0] bg);
        if (palette_pkg::ship_palette[code] == palette_pkg::key_color)
            return bg;
        return palette_pkg::ship_palette[code];
    endfunction

    function automatic bit on_torpedo(input int x, input int y);
        for (int p = 0; p < 2; p++)
            for (int i = 0; i < vga_pkg::torp_slots; i++)
                if (m_active[p][i] && (x >= m_tx[p][i]) && (x < m_tx[p][i] + 4) &&
                    (y >= m_ty[p][i]) && (y < m_ty[p][i] + 2))
                    return 1'b1;
        return 1'b0;
    endfunction

    function automatic logic [23:0] expected_color(input int x, input int y);
        logic [23:0] bg;
        int s1x;
        int s1y;
        int s2x;
        int s2y;
        s1x = int'(ship1_x);
        s1y = int'(ship1_y);
        s2x = int'(ship2_x);
        s2y = int'(ship2_y);
        bg = palette_pkg::background_palette[((x / tile_px) + (y / tile_px)) % 3];
        if ((x >= 640) || (y >= 480))
            return 24'h0;
        // Ship 1 on top of ship 2 on top of shots
        if (on_ship(x, y, s1x, s1y))
            return ship_or_background(cell_code(x, y, s1x, s1y), bg);
        if (on_ship(x, y, s2x, s2y))
            return ship_or_background(cell_code(x, y, s2x, s2y), bg);
        if (on_torpedo(x, y))
            return palette_pkg::torp_color;
        return bg;
    endfunction

    // Tally visible pixels in the ship overlap and uncovered shots
    task automatic count_coverage(input int x, input int y);
        bit s1;
        bit s2;
        s1 = on_ship(x, y, int'(ship1_x), int'(ship1_y));
        s2 = on_ship(x, y, int'(ship2_x), int'(ship2_y));
        if ((x < 640) && (y < 480))
        begin
            if (s1 && s2)
                overlap_pixels++;
            else if (!s1 && !s2 && on_torpedo(x, y))
                shot_pixels++;
        end
    endtask

    // Next-edge state from launches, frame moves and the scan step
    task automatic advance_model();
        bit new_frame;
        bit fire_in [2];
        int sx [2];
        int sy [2];
        int free_slot;
        int new_x;
        new_frame  = (scan_x == 0) && (scan_y == 0) && (frame_count > 0);
        fire_in[0] = fire1;
        fire_in[1] = fire2;
        sx[0] = int'(ship1_x);
        sy[0] = int'(ship1_y);
        sx[1] = int'(ship2_x);
        sy[1] = int'(ship2_y);
        for (int p = 0; p < 2; p++)
        begin
            free_slot = -1;
            for (int i = vga_pkg::torp_slots - 1; i >= 0; i--)
                if (!m_active[p][i])
                    free_slot = i;
            for (int i = 0; i < vga_pkg::torp_slots; i++)
            begin
                if (fire_in[p] && (free_slot == i))
                begin
                    // Player 2 shoots left from behind its corner
                    m_active[p][i] = 1'b1;
                    m_tx[p][i] = (p == 1) ? sx[p] - launch_back : sx[p] + launch_ahead;
                    m_ty[p][i] = sy[p] + launch_drop;
                end
                else if (new_frame && m_active[p][i])
                begin
                    new_x = (p == 1) ? m_tx[p][i] - 8 : m_tx[p][i] + 8;
                    if ((new_x < 0) || (new_x > 639))
                        m_active[p][i] = 1'b0;
                    else
                        m_tx[p][i] = new_x;
                end
            end
        end
        scan_x++;
        if (scan_x == vga_pkg::h_total)
        begin
            scan_x = 0;
            scan_y++;
            if (scan_y == vga_pkg::v_total)
            begin
                scan_y = 0;
                frame_count++;
            end
        end
    endtask

    task automatic report_mismatch(input string signal, input int expected, input int actual);
        $display("ERROR at %0t: %s expected 0x%0h, actual 0x%0h", $time, signal, expected,
                 actual);
        $display("Test failed");
        $fatal(1);
    endtask

    // --------------------
    // Checks at the falling edge against the previous scan position
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            chk_r: assert (vga_r == exp_rgb[23:16])
                else report_mismatch("vga_r", int'(exp_rgb[23:16]), int'(vga_r));
            chk_g: assert (vga_g == exp_rgb[15:8])
                else report_mismatch("vga_g", int'(exp_rgb[15:8]), int'(vga_g));
            chk_b: assert (vga_b == exp_rgb[7:0])
                else report_mismatch("vga_b", int'(exp_rgb[7:0]), int'(vga_b));
            chk_hs: assert (vga_hs == exp_hs)
                else report_mismatch("vga_hs", int'(exp_hs), int'(vga_hs));
            chk_vs: assert (vga_vs == exp_vs)
                else report_mismatch("vga_vs", int'(exp_vs), int'(vga_vs));
            exp_rgb = expected_color(scan_x, scan_y);
            exp_hs = !((scan_x >= 656) && (scan_x <= 751));
            exp_vs = !((scan_y >= 490) && (scan_y <= 491));
            count_coverage(scan_x, scan_y);
            advance_model();
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout: three frames not scanned within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    // --------------------
    // Stimulus helpers
    task automatic wait_line(input int frame, input int line);
        while (!((frame_count == frame) && (scan_y == line)))
            @(posedge clk);
    endtask

    task automatic place_ship(input int player, input int x, input int y);
        @(posedge clk);
        if (player == 1)
        begin
            ship1_x <= vga_pkg::coord_w'(x);
            ship1_y <= vga_pkg::coord_w'(y);
        end
        else
        begin
            ship2_x <= vga_pkg::coord_w'(x);
            ship2_y <= vga_pkg::coord_w'(y);
        end
    endtask

    task automatic place_random(input int player);
        int x;
        int y;
        take_bits(10, x);
        take_bits(9, y);
        place_ship(player, col_min + x % (col_max - col_min + 1),
                   row_min + y % (row_max - row_min + 1));
    endtask

    // One-cycle fire strobes
    task automatic pulse_fire(input bit f1, input bit f2);
        @(posedge clk);
        fire1 <= f1;
        fire2 <= f2;
        @(posedge clk);
        fire1 <= 1'b0;
        fire2 <= 1'b0;
    endtask

    initial
    begin
        int x1;
        int y1;
        int dx;
        int dy;
        rst_n   = 1'b0;
        fire1   = 1'b0;
        fire2   = 1'b0;
        ship1_x = '0;
        ship1_y = '0;
        ship2_x = '0;
        ship2_y = '0;
        $readmemh("ship_sprite.mem", bitmap);

        // Overlapping ships for frame 0 placed during reset
        take_bits(10, x1);
        take_bits(9, y1);
        take_bits(3, dx);
        take_bits(3, dy);
        x1 = col_min + x1 % (col_max - col_min + 1);
        y1 = row_min + y1 % (row_max - row_min + 1);
        place_ship(1, x1, y1);
        place_ship(2, x1 + dx, y1 + dy);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // First shots fired above the ships and drawn under the overlap
        wait_line(0, 20);
        pulse_fire(1'b1, 1'b1);

        // Edge shots in slot 1 of each bank during vertical blank
        wait_line(0, 485);
        take_bits(9, y1);
        place_ship(1, edge_x_right, row_min + y1 % (row_max - row_min + 1));
        take_bits(9, y1);
        place_ship(2, edge_x_left, row_min + y1 % (row_max - row_min + 1));
        pulse_fire(1'b1, 1'b1);

        // Fill slots 2 and 3 so the third round hits full banks
        repeat (3)
        begin
            place_random(1);
            place_random(2);
            pulse_fire(1'b1, 1'b1);
        end
        place_random(1);
        place_random(2);

        wait_line(1, 240);
        place_random(1);
        place_random(2);

        // Edge shots retired at this frame start leave slot 1 free
        wait_line(2, 10);
        place_random(1);
        place_random(2);
        pulse_fire(1'b1, 1'b1);
        place_random(1);
        place_random(2);
        pulse_fire(1'b1, 1'b1);

        wait_line(run_frames, 0);
        repeat (4) @(posedge clk);
        if ((overlap_pixels > 0) && (shot_pixels > 0))
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("Stimulus never showed both a ship overlap and an uncovered torpedo");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
